// File: verilog.f
+incdir+test
common/mips_ex_pkg.sv
alu/alu_datapath.sv
alu/cond_unit.sv
axi_regs/axi_lite_regs.sv
design/ex_result_merge.sv
design/mips_ex_top.sv
test/tb_mips_ex_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_mips_ex_top -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/tb_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "Test completed successfully"; then
	exit 0
else
	exit 1
fi

// File: test/tb_axi_tasks.svh
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

localparam int TIMEOUT = 200; // Cycles allowed per wait loop
localparam logic [DATA_W-1:0] SIGN_BIT = 32'h80000000;

// AW and W go out together and drop on the accept edge
task automatic write_req(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
		input logic [STRB_W-1:0] strb);
	int cnt;
	cnt = 0;
	s_axi_awaddr <= addr;
	s_axi_wdata <= data;
	s_axi_wstrb <= strb;
	s_axi_awvalid <= 1'b1;
	s_axi_wvalid <= 1'b1;
	do begin
		@(posedge clk);
		cnt++;
	end while (!(s_axi_awready && s_axi_wready) && cnt < TIMEOUT);
	if (!(s_axi_awready && s_axi_wready))
		abort_run("slave never accepted the write address and data");
	else begin
		s_axi_awvalid <= 1'b0;
		s_axi_wvalid <= 1'b0;
	end
endtask

task automatic write_rsp(output logic [1:0] resp);
	int cnt;
	cnt = 0;
	s_axi_bready <= 1'b1;
	do begin
		@(posedge clk);
		cnt++;
	end while (!(s_axi_bvalid && s_axi_bready) && cnt < TIMEOUT);
	if (!s_axi_bvalid)
		abort_run("no write response came back");
	else begin
		resp = s_axi_bresp;
		s_axi_bready <= 1'b0;
	end
endtask

task automatic axi_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
		output logic [1:0] resp);
	int cnt;
	cnt = 0;
	s_axi_araddr <= addr;
	s_axi_arvalid <= 1'b1;
	s_axi_rready <= 1'b1; // No read back-pressure here
	do begin
		@(posedge clk);
		cnt++;
	end while (!s_axi_arready && cnt < TIMEOUT);
	if (!s_axi_arready)
		abort_run("slave never accepted the read address");
	else begin
		s_axi_arvalid <= 1'b0;
		cnt = 0; // Fresh budget for the data phase
		do begin
			@(posedge clk);
			cnt++;
		end while (!s_axi_rvalid && cnt < TIMEOUT);
		if (!s_axi_rvalid)
			abort_run("read data never returned");
		else begin
			data = s_axi_rdata;
			resp = s_axi_rresp;
			s_axi_rready <= 1'b0;
		end
	end
endtask

task automatic check_result(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
		input string what);
	check_count++;
	if (got !== exp) begin
		err_count++;
		$display("FAILED at %0t: %s data %h, expected %h", $time, what, got, exp);
	end
endtask

task automatic check_status(input logic [ST_W-1:0] got, input logic [ST_W-1:0] exp,
		input string what);
	check_count++;
	if (got !== exp) begin
		err_count++;
		$display("FAILED at %0t: %s status %b, expected %b", $time, what, got, exp);
	end
endtask

task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
	check_count++;
	if (got !== exp) begin
		err_count++;
		$display("FAILED at %0t: %s %b, expected %b", $time, what, got, exp);
	end
endtask

// Expected RESULT and STATUS for one launch
function automatic void model_op(input logic [OP_W-1:0] code, input logic eq,
		input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
		output logic [DATA_W-1:0] res, output logic [ST_W-1:0] st);
	logic [DATA_W:0] wide; // One extra sign bit
	logic ovf;
	wide = '0;
	st = '0;
	st[ST_DONE] = 1'b1;
	case (code)
		OP_AND: res = a & b;
		OP_OR: res = a | b;
		OP_ADD, OP_SUB: begin
			if (code == OP_ADD)
				wide = {a[DATA_W-1], a} + {b[DATA_W-1], b};
			else
				wide = {a[DATA_W-1], a} - {b[DATA_W-1], b};
			ovf = wide[DATA_W] != wide[DATA_W-1]; // Top two bits disagree
			res = ovf ? '0 : wide[DATA_W-1:0];
			st[ST_OVERFLOW] = ovf;
			if (code == OP_SUB)
				st[ST_BRANCH] = (a == b) == eq; // BEQ or BNE
		end
		OP_ADDU: res = a + b;
		OP_MOVN: begin
			st[ST_MOVN] = |b;
			res = |b ? a : '0;
		end
		OP_SUBU: res = a - b;
		OP_BGEZ: begin
			st[ST_BRANCH] = ~a[DATA_W-1];
			res = {{(DATA_W-1){1'b0}}, ~a[DATA_W-1]};
		end
		OP_SLT: res = {{(DATA_W-1){1'b0}}, (a ^ SIGN_BIT) < (b ^ SIGN_BIT)}; // Biased order
		OP_SLTU: res = {{(DATA_W-1){1'b0}}, a < b};
		OP_NOR: res = ~(a | b);
		OP_XOR: res = a ^ b;
		OP_LUI: res = {b[15:0], 16'h0000};
		default: begin
			res = ILLEGAL_RESULT;
			st[ST_ILLEGAL] = 1'b1;
		end
	endcase
endfunction

`endif

// File: test/tb_mips_ex_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_ex_top;
	import mips_ex_pkg::*;

	logic clk;
	logic rst;
	logic [ADDR_W-1:0] s_axi_awaddr;
	logic s_axi_awvalid;
	logic s_axi_awready;
	logic [DATA_W-1:0] s_axi_wdata;
	logic [STRB_W-1:0] s_axi_wstrb;
	logic s_axi_wvalid;
	logic s_axi_wready;
	logic [1:0] s_axi_bresp;
	logic s_axi_bvalid;
	logic s_axi_bready;
	logic [ADDR_W-1:0] s_axi_araddr;
	logic s_axi_arvalid;
	logic s_axi_arready;
	logic [DATA_W-1:0] s_axi_rdata;
	logic [1:0] s_axi_rresp;
	logic s_axi_rvalid;
	logic s_axi_rready;
	int err_count; // Wrong values seen
	int check_count;

	mips_ex_top dut0 (.*);

	// Hung handshake ends the run
	task automatic abort_run(input string why);
		$display("Timeout: %s", why);
		$display("Test failed");
		$finish;
	endtask

	`include "tb_axi_tasks.svh"

	task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
			input logic [STRB_W-1:0] strb, input logic [1:0] exp_resp);
		logic [1:0] resp;
		write_req(addr, data, strb);
		write_rsp(resp);
		check_resp(resp, exp_resp, "write response");
	endtask

	task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
			input logic [1:0] exp_resp);
		logic [1:0] resp;
		axi_read(addr, data, resp);
		check_resp(resp, exp_resp, "read response");
	endtask

	// Operands, launch, then RESULT and STATUS against the model
	task automatic run_op(input logic [OP_W-1:0] code, input logic eq,
			input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
		logic [DATA_W-1:0] exp_res;
		logic [ST_W-1:0] exp_st;
		logic [DATA_W-1:0] rd;
		model_op(code, eq, a, b, exp_res, exp_st);
		write_reg(REG_OPA, a, '1, RESP_OKAY);
		write_reg(REG_OPB, b, '1, RESP_OKAY);
		write_reg(REG_CTRL, {27'd0, eq, code}, 4'h1, RESP_OKAY);
		read_reg(REG_RESULT, rd, RESP_OKAY);
		check_result(rd, exp_res, $sformatf("op %0d", code));
		read_reg(REG_STATUS, rd, RESP_OKAY);
		check_status(rd[ST_W-1:0], exp_st, $sformatf("op %0d", code));
	endtask

	task automatic report_test(input string name, input int errs_before);
		$display("%s: done, %0d error(s)", name, err_count - errs_before);
	endtask

	task automatic logic_ops_run();
		logic [OP_W-1:0] codes [7] = '{OP_AND, OP_OR, OP_NOR, OP_XOR, OP_ADDU, OP_SUBU, OP_LUI};
		int e0;
		e0 = err_count;
		foreach (codes[i])
			repeat (4) run_op(codes[i], 1'b0, $urandom, $urandom);
		report_test("logic and unsigned ops", e0);
	endtask

	task automatic add_sub_limits();
		int e0;
		e0 = err_count;
		run_op(OP_ADD, 1'b0, 32'h7fffffff, 32'h00000001); // max+1
		run_op(OP_ADD, 1'b0, 32'h80000000, 32'hffffffff); // min-1 as add
		run_op(OP_SUB, 1'b0, 32'h80000000, 32'h00000001); // min-1
		run_op(OP_SUB, 1'b0, 32'h80000000, 32'h7fffffff); // min-max
		run_op(OP_SUB, 1'b0, 32'h7fffffff, 32'hffffffff);
		run_op(OP_ADD, 1'b0, 32'h7ffffffe, 32'h00000001); // Right at the edge
		run_op(OP_ADD, 1'b0, 32'hfffffffd, 32'h00000005);
		run_op(OP_SUB, 1'b0, 32'hffffffff, 32'h7fffffff); // Lands on min
		run_op(OP_SUB, 1'b0, 32'h00000010, 32'h00000003);
		report_test("add/sub overflow", e0);
	endtask

	task automatic compare_ops();
		logic [OP_W-1:0] slt_ops [2] = '{OP_SLT, OP_SLTU};
		int e0;
		e0 = err_count;
		foreach (slt_ops[i]) begin
			run_op(slt_ops[i], 1'b0, 32'hffffffff, 32'h00000001); // Orders disagree
			run_op(slt_ops[i], 1'b0, 32'h00000001, 32'hffffffff);
			run_op(slt_ops[i], 1'b0, 32'h80000000, 32'h7fffffff);
			run_op(slt_ops[i], 1'b0, 32'h00000005, 32'h00000005);
		end
		run_op(OP_SUB, 1'b1, 32'h00000042, 32'h00000042); // BEQ taken
		run_op(OP_SUB, 1'b1, 32'h00000042, 32'h00000043);
		run_op(OP_SUB, 1'b0, 32'h00000042, 32'h00000042);
		run_op(OP_SUB, 1'b0, 32'h00000042, 32'h00000043); // BNE taken
		run_op(OP_BGEZ, 1'b0, 32'h00000007, 32'h0);
		run_op(OP_BGEZ, 1'b0, 32'h00000000, 32'h0);
		run_op(OP_BGEZ, 1'b0, 32'h80000000, 32'h0);
		report_test("compare and branch", e0);
	endtask

	task automatic movn_cases();
		int e0;
		e0 = err_count;
		run_op(OP_MOVN, 1'b0, 32'h0000cafe, 32'h00000000);
		run_op(OP_MOVN, 1'b0, 32'h0000cafe, 32'h00000001);
		run_op(OP_MOVN, 1'b0, $urandom, 32'h80000000);
		report_test("movn", e0);
	endtask

	task automatic error_paths();
		logic [DATA_W-1:0] rd;
		int e0;
		e0 = err_count;
		run_op(4'd5, 1'b0, $urandom, $urandom);
		run_op(4'd11, 1'b0, $urandom, $urandom);
		run_op(4'd14, 1'b1, $urandom, $urandom);
		run_op(OP_ADDU, 1'b0, 32'h00000100, 32'h00000023); // Known state, RESULT 0x123
		write_reg(REG_RESULT, 32'h12345678, '1, RESP_SLVERR);
		write_reg(REG_STATUS, 32'h0000001f, '1, RESP_SLVERR);
		write_reg(5'h14, 32'hffffffff, '1, RESP_SLVERR);
		read_reg(REG_RESULT, rd, RESP_OKAY);
		check_result(rd, 32'h00000123, "RESULT after rejected writes");
		read_reg(REG_STATUS, rd, RESP_OKAY);
		check_status(rd[ST_W-1:0], 5'b1 << ST_DONE, "STATUS after rejected writes");
		read_reg(REG_OPB, rd, RESP_OKAY);
		check_result(rd, 32'h00000023, "OPB after rejected writes");
		read_reg(5'h14, rd, RESP_SLVERR);
		check_result(rd, '0, "unmapped read");
		write_reg(REG_OPA, 32'haabbccdd, 4'b0101, RESP_OKAY); // Bytes 0 and 2 only
		read_reg(REG_OPA, rd, RESP_OKAY);
		check_result(rd, 32'h00bb01dd, "OPA after partial strobe");
		report_test("illegal ops and bus errors", e0);
	endtask

	task automatic bready_backpressure();
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] exp_res;
		logic [ST_W-1:0] exp_st;
		logic [DATA_W-1:0] rd;
		logic [1:0] resp;
		int hold;
		int e0;
		e0 = err_count;
		repeat (3) begin
			a = $urandom;
			b = $urandom;
			hold = int'($urandom_range(12, 2));
			model_op(OP_ADDU, 1'b0, a, b, exp_res, exp_st);
			write_reg(REG_OPA, a, '1, RESP_OKAY);
			write_reg(REG_OPB, b, '1, RESP_OKAY);
			write_req(REG_CTRL, {27'd0, 1'b0, OP_ADDU}, 4'h1); // bready stays low
			repeat (hold) begin
				@(posedge clk);
				if (!s_axi_bvalid) begin
					err_count++;
					$display("bvalid dropped while bready was low, at %0t", $time);
				end
			end
			read_reg(REG_RESULT, rd, RESP_OKAY); // B still pending
			check_result(rd, exp_res, "RESULT while B is held");
			write_rsp(resp);
			check_resp(resp, RESP_OKAY, "held write response");
			read_reg(REG_RESULT, rd, RESP_OKAY);
			check_result(rd, exp_res, "RESULT after B handshake");
		end
		report_test("write back-pressure", e0);
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		void'($urandom(32'h612f));
		err_count = 0;
		check_count = 0;
		rst = 1'b1;
		s_axi_awaddr = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata = '0;
		s_axi_wstrb = '0;
		s_axi_wvalid = 1'b0;
		s_axi_bready = 1'b0;
		s_axi_araddr = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready = 1'b0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		logic_ops_run();
		add_sub_limits();
		compare_ops();
		movn_cases();
		error_paths();
		bready_backpressure();
		$display("checks %0d, errors %0d", check_count, err_count);
		if (err_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: design/mips_ex_top.sv
`timescale 1ns/1ps
`default_nettype none

module mips_ex_top (
	input  logic clk,
	input  logic rst,
	input  logic [mips_ex_pkg::ADDR_W-1:0] s_axi_awaddr,
	input  logic s_axi_awvalid,
	output logic s_axi_awready,
	input  logic [mips_ex_pkg::DATA_W-1:0] s_axi_wdata,
	input  logic [mips_ex_pkg::STRB_W-1:0] s_axi_wstrb,
	input  logic s_axi_wvalid,
	output logic s_axi_wready,
	output logic [1:0] s_axi_bresp,
	output logic s_axi_bvalid,
	input  logic s_axi_bready,
	input  logic [mips_ex_pkg::ADDR_W-1:0] s_axi_araddr,
	input  logic s_axi_arvalid,
	output logic s_axi_arready,
	output logic [mips_ex_pkg::DATA_W-1:0] s_axi_rdata,
	output logic [1:0] s_axi_rresp,
	output logic s_axi_rvalid,
	input  logic s_axi_rready
);
	import mips_ex_pkg::*;

	logic [DATA_W-1:0] opa; // Registered operands
	logic [DATA_W-1:0] opb;
	alu_op_e op;
	logic equal; // BEQ/BNE select
	logic start; // Launch pulse
	logic [DATA_W-1:0] arith_result;
	logic overflow;
	logic branch;
	logic movn_en;
	logic less;
	logic [DATA_W-1:0] result; // Back to the register block
	logic [ST_W-1:0] status;
	logic done;

	axi_lite_regs u_regs (
		.clk(clk),
		.rst(rst),
		.s_axi_awaddr(s_axi_awaddr),
		.s_axi_awvalid(s_axi_awvalid),
		.s_axi_awready(s_axi_awready),
		.s_axi_wdata(s_axi_wdata),
		.s_axi_wstrb(s_axi_wstrb),
		.s_axi_wvalid(s_axi_wvalid),
		.s_axi_wready(s_axi_wready),
		.s_axi_bresp(s_axi_bresp),
		.s_axi_bvalid(s_axi_bvalid),
		.s_axi_bready(s_axi_bready),
		.s_axi_araddr(s_axi_araddr),
		.s_axi_arvalid(s_axi_arvalid),
		.s_axi_arready(s_axi_arready),
		.s_axi_rdata(s_axi_rdata),
		.s_axi_rresp(s_axi_rresp),
		.s_axi_rvalid(s_axi_rvalid),
		.s_axi_rready(s_axi_rready),
		.result(result),
		.status(status),
		.done(done),
		.opa(opa),
		.opb(opb),
		.op(op),
		.equal(equal),
		.start(start)
	);

	// Arithmetic side
	alu_datapath u_dp (
		.opa(opa),
		.opb(opb),
		.op(op),
		.arith_result(arith_result),
		.overflow(overflow)
	);

	// Compare side, runs in parallel
	cond_unit u_cond (
		.opa(opa),
		.opb(opb),
		.op(op),
		.equal(equal),
		.branch(branch),
		.movn_en(movn_en),
		.less(less)
	);

	ex_result_merge u_merge (
		.clk(clk),
		.rst(rst),
		.start(start),
		.op(op),
		.arith_result(arith_result),
		.overflow(overflow),
		.branch(branch),
		.movn_en(movn_en),
		.less(less),
		.result(result),
		.status(status),
		.done(done)
	);

endmodule

`default_nettype wire

// File: design/ex_result_merge.sv
`timescale 1ns/1ps
`default_nettype none

module ex_result_merge (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  mips_ex_pkg::alu_op_e op,
	input  logic [mips_ex_pkg::DATA_W-1:0] arith_result,
	input  logic overflow,
	input  logic branch,
	input  logic movn_en,
	input  logic less,
	output logic [mips_ex_pkg::DATA_W-1:0] result,
	output logic [mips_ex_pkg::ST_W-1:0] status,
	output logic done
);
	import mips_ex_pkg::*;

	logic [DATA_W-1:0] res_next; // Selected result
	logic illegal; // Opcode in a hole

	always_comb begin
		res_next = arith_result;
		illegal = 1'b0;
		case (op)
			OP_SLT, OP_SLTU: res_next = {{(DATA_W-1){1'b0}}, less}; // Zero extended
			OP_BGEZ: res_next = {{(DATA_W-1){1'b0}}, branch};
			OP_MOVN: res_next = movn_en ? arith_result : '0;
			OP_ADD, OP_SUB: res_next = overflow ? '0 : arith_result; // Trap clears result
			OP_AND, OP_OR, OP_ADDU, OP_SUBU, OP_NOR, OP_XOR, OP_LUI: res_next = arith_result;
			default: begin
				res_next = ILLEGAL_RESULT;
				illegal = 1'b1;
			end
		endcase
	end

	// Result and flags load one cycle after the CTRL accept
	always_ff @(posedge clk) begin
		if (rst) begin
			result <= '0;
			status <= '0;
		end else if (start) begin
			result <= res_next;
			status[ST_OVERFLOW] <= overflow;
			status[ST_BRANCH] <= branch;
			status[ST_MOVN] <= movn_en;
			status[ST_ILLEGAL] <= illegal;
			status[ST_DONE] <= 1'b1;
		end
	end

	assign done = status[ST_DONE];

	a_movn_only: assert property (@(posedge clk) disable iff (rst)
		movn_en |-> op == OP_MOVN);

endmodule

`default_nettype wire

// File: axi_regs/axi_lite_regs.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_regs (
	input  logic clk,
	input  logic rst,
	input  logic [mips_ex_pkg::ADDR_W-1:0] s_axi_awaddr,
	input  logic s_axi_awvalid,
	output logic s_axi_awready,
	input  logic [mips_ex_pkg::DATA_W-1:0] s_axi_wdata,
	input  logic [mips_ex_pkg::STRB_W-1:0] s_axi_wstrb,
	input  logic s_axi_wvalid,
	output logic s_axi_wready,
	output logic [1:0] s_axi_bresp,
	output logic s_axi_bvalid,
	input  logic s_axi_bready,
	input  logic [mips_ex_pkg::ADDR_W-1:0] s_axi_araddr,
	input  logic s_axi_arvalid,
	output logic s_axi_arready,
	output logic [mips_ex_pkg::DATA_W-1:0] s_axi_rdata,
	output logic [1:0] s_axi_rresp,
	output logic s_axi_rvalid,
	input  logic s_axi_rready,
	input  logic [mips_ex_pkg::DATA_W-1:0] result,
	input  logic [mips_ex_pkg::ST_W-1:0] status,
	input  logic done,
	output logic [mips_ex_pkg::DATA_W-1:0] opa,
	output logic [mips_ex_pkg::DATA_W-1:0] opb,
	output mips_ex_pkg::alu_op_e op,
	output logic equal,
	output logic start
);
	import mips_ex_pkg::*;

	logic wr_go; // Take a write this edge
	logic rd_go; // Take a read this edge
	logic [ST_W-1:0] status_rd; // Status as seen by the host

	// Idle means no ready pulse in flight and no response waiting
	assign wr_go = s_axi_awvalid && s_axi_wvalid && !s_axi_awready && !s_axi_bvalid;
	assign rd_go = s_axi_arvalid && !s_axi_arready && !s_axi_rvalid;

	always_comb begin
		status_rd = status;
		status_rd[ST_DONE] = done && !start; // Reads 0 while an op is launching
	end

	// Write control and register file
	always_ff @(posedge clk) begin
		if (rst) begin
			s_axi_awready <= 1'b0;
			s_axi_wready <= 1'b0;
			s_axi_bvalid <= 1'b0;
			opa <= '0;
			opb <= '0;
			op <= OP_AND;
			equal <= 1'b0;
			start <= 1'b0;
		end else begin
			start <= 1'b0; // Single cycle launch
			s_axi_awready <= wr_go; // Both readies pulse together
			s_axi_wready <= wr_go;
			if (wr_go) begin
				case (s_axi_awaddr)
					REG_OPA: begin
						for (int i = 0; i < STRB_W; i++) begin
							if (s_axi_wstrb[i])
								opa[i*8 +: 8] <= s_axi_wdata[i*8 +: 8]; // Byte merge
						end
					end
					REG_OPB: begin
						for (int i = 0; i < STRB_W; i++) begin
							if (s_axi_wstrb[i])
								opb[i*8 +: 8] <= s_axi_wdata[i*8 +: 8];
						end
					end
					REG_CTRL: begin
						if (s_axi_wstrb[0]) begin
							op <= alu_op_e'(s_axi_wdata[OP_W-1:0]); // Holes kept for illegal check
							equal <= s_axi_wdata[OP_W];
						end
						start <= 1'b1; // Launch on accept cycle
					end
					default: ; // RESULT, STATUS, unmapped are ignored
				endcase
			end
			// B lands with the merge stage register update
			if (s_axi_awready)
				s_axi_bvalid <= 1'b1;
			else if (s_axi_bvalid && s_axi_bready)
				s_axi_bvalid <= 1'b0;
		end
	end

	// Write response code
	always_ff @(posedge clk) begin
		if (wr_go) begin
			case (s_axi_awaddr)
				REG_OPA, REG_OPB, REG_CTRL: s_axi_bresp <= RESP_OKAY;
				default: s_axi_bresp <= RESP_SLVERR; // Read only or unmapped
			endcase
		end
	end

	// Read handshake
	always_ff @(posedge clk) begin
		if (rst) begin
			s_axi_arready <= 1'b0;
			s_axi_rvalid <= 1'b0;
		end else begin
			s_axi_arready <= rd_go; // One cycle pulse
			if (s_axi_arready)
				s_axi_rvalid <= 1'b1;
			else if (s_axi_rvalid && s_axi_rready)
				s_axi_rvalid <= 1'b0;
		end
	end

	// Read data, sampled on the AR handshake edge
	always_ff @(posedge clk) begin
		if (s_axi_arready) begin
			s_axi_rresp <= RESP_OKAY;
			case (s_axi_araddr)
				REG_OPA: s_axi_rdata <= opa;
				REG_OPB: s_axi_rdata <= opb;
				REG_CTRL: s_axi_rdata <= {{(DATA_W-OP_W-1){1'b0}}, equal, op};
				REG_RESULT: s_axi_rdata <= result;
				REG_STATUS: s_axi_rdata <= {{(DATA_W-ST_W){1'b0}}, status_rd};
				default: begin
					s_axi_rdata <= '0; // Unmapped
					s_axi_rresp <= RESP_SLVERR;
				end
			endcase
		end
	end

	a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
		s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);
	a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
		s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata));
	a_start_pulse: assert property (@(posedge clk) disable iff (rst)
		start |=> !start);

endmodule

`default_nettype wire

// File: alu/cond_unit.sv
`timescale 1ns/1ps
`default_nettype none

module cond_unit (
	input  logic [mips_ex_pkg::DATA_W-1:0] opa,
	input  logic [mips_ex_pkg::DATA_W-1:0] opb,
	input  mips_ex_pkg::alu_op_e op,
	input  logic equal,
	output logic branch,
	output logic movn_en,
	output logic less
);
	import mips_ex_pkg::*;

	logic ops_eq; // Operand equality
	logic lt_s; // Signed less than
	logic lt_u; // Unsigned less than

	assign ops_eq = (opa == opb);
	assign lt_s = $signed(opa) < $signed(opb);
	assign lt_u = opa < opb;

	always_comb begin
		branch = 1'b0;
		movn_en = 1'b0;
		less = 1'b0;
		case (op)
			OP_SUB: branch = (ops_eq == equal); // BEQ when equal=1, BNE when 0
			OP_BGEZ: branch = !opa[DATA_W-1]; // Non-negative
			OP_MOVN: movn_en = (opb != '0); // rt nonzero enables write
			OP_SLT: less = lt_s;
			OP_SLTU: less = lt_u;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: alu/alu_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module alu_datapath (
	input  logic [mips_ex_pkg::DATA_W-1:0] opa,
	input  logic [mips_ex_pkg::DATA_W-1:0] opb,
	input  mips_ex_pkg::alu_op_e op,
	output logic [mips_ex_pkg::DATA_W-1:0] arith_result,
	output logic overflow
);
	import mips_ex_pkg::*;

	logic [DATA_W-1:0] sum; // Shared adder
	logic [DATA_W-1:0] diff; // Shared subtractor
	logic add_ovf; // Same signs in, other sign out
	logic sub_ovf; // Signs differ, result flips from opa
	logic [DATA_W:0] exact; // Sign extended result, never wraps

	assign sum = opa + opb;
	assign diff = opa - opb;
	assign add_ovf = (opa[DATA_W-1] == opb[DATA_W-1]) && (sum[DATA_W-1] != opa[DATA_W-1]);
	assign sub_ovf = (opa[DATA_W-1] != opb[DATA_W-1]) && (diff[DATA_W-1] != opa[DATA_W-1]);
	assign exact = (op == OP_SUB) ? {opa[DATA_W-1], opa} - {opb[DATA_W-1], opb}
		: {opa[DATA_W-1], opa} + {opb[DATA_W-1], opb};

	always_comb begin
		arith_result = '0; // Compare ops are filled in by the merge stage
		overflow = 1'b0;
		case (op)
			OP_AND: arith_result = opa & opb;
			OP_OR: arith_result = opa | opb;
			OP_ADD: begin
				arith_result = sum;
				overflow = add_ovf; // Trapped, merge zeroes result
			end
			OP_ADDU: arith_result = sum; // No trap
			OP_MOVN: arith_result = opa; // Candidate, gated by movn_en later
			OP_SUB: begin
				arith_result = diff;
				overflow = sub_ovf;
			end
			OP_SUBU: arith_result = diff;
			OP_NOR: arith_result = ~(opa | opb);
			OP_XOR: arith_result = opa ^ opb;
			OP_LUI: arith_result = opb << 16; // Low half into upper
			default: ;
		endcase
	end

	// Overflow only for trapping ops whose exact result leaves 32 bits
	always_comb begin
		a_ovf_op: assert (overflow == ((op == OP_ADD || op == OP_SUB)
			&& exact[DATA_W] != exact[DATA_W-1]));
	end

endmodule

`default_nettype wire

// File: common/mips_ex_pkg.sv
`default_nettype none

package mips_ex_pkg;

	localparam int DATA_W = 32; // Datapath width
	localparam int ADDR_W = 5; // AXI4-Lite address width
	localparam int OP_W = 4; // Opcode field width
	localparam int ST_W = 5; // Status register width
	localparam int STRB_W = DATA_W / 8; // Byte lanes

	// ALU opcodes, holes at 5, 11 and 14 are illegal
	typedef enum logic [OP_W-1:0] {
		OP_AND  = 4'd0,
		OP_OR   = 4'd1,
		OP_ADD  = 4'd2, // Signed, traps overflow
		OP_ADDU = 4'd3,
		OP_MOVN = 4'd4, // Move if opb nonzero
		OP_SUB  = 4'd6, // Also BEQ/BNE test
		OP_SUBU = 4'd7,
		OP_BGEZ = 4'd8,
		OP_SLT  = 4'd9,
		OP_SLTU = 4'd10,
		OP_NOR  = 4'd12,
		OP_XOR  = 4'd13,
		OP_LUI  = 4'd15 // opb into upper half
	} alu_op_e;

	// Register map
	localparam logic [ADDR_W-1:0] REG_OPA    = 5'h00;
	localparam logic [ADDR_W-1:0] REG_OPB    = 5'h04;
	localparam logic [ADDR_W-1:0] REG_CTRL   = 5'h08; // op in 3:0, equal in 4
	localparam logic [ADDR_W-1:0] REG_RESULT = 5'h0C; // Read only
	localparam logic [ADDR_W-1:0] REG_STATUS = 5'h10; // Read only

	// Status bit positions
	localparam int ST_OVERFLOW = 0;
	localparam int ST_BRANCH   = 1;
	localparam int ST_MOVN     = 2;
	localparam int ST_ILLEGAL  = 3;
	localparam int ST_DONE     = 4;

	localparam logic [DATA_W-1:0] ILLEGAL_RESULT = 32'hdeadbeef; // Marker for bad opcode

	// AXI response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire
